// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := lsu_tb
RTL_TOP    := lsu_top
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '>>> FAIL' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '>>> PASS' $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
source/lsu_pkg.sv
source/mem_issue.sv
source/data_ram.sv
source/wb_stage.sv
source/lsu_top.sv
tests/lsu_sva.sv
tests/lsu_tb.sv

// ==== source/data_ram.sv ====
// Word-organized data RAM on a Wishbone classic slave port with one wait state
`timescale 1ns/1ps

module data_ram #(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lsu_pkg::wbm_req_t wbm_i,
  output lsu_pkg::wbs_rsp_t wbs_o
);
  import lsu_pkg::*;

  // Index width, at least one bit
  localparam int unsigned AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [XLEN-1:0] mem [RAM_WORDS];

  logic            start;
  logic            hit;
  logic [AW-1:0]   idx;
  logic            ack_q;
  logic            err_q;
  logic [XLEN-1:0] dat_q;

  // New access only once per cycle, not again in the reply cycle
  assign start = wbm_i.cyc & wbm_i.stb & ~ack_q & ~err_q;
  assign hit   = (wbm_i.adr < RAM_WORDS);
  assign idx   = wbm_i.adr[AW+1:2];

  ////////////////////////////////////////////////////////////
  // Reply, one cycle after stb
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= start & hit;
      err_q <= start & ~hit;
    end
  end

  // Array access; out-of-range leaves memory alone
  always_ff @(posedge clk_i) begin
    if (start && hit) begin
      if (wbm_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (wbm_i.sel[b]) mem[idx][8*b +: 8] <= wbm_i.dat[8*b +: 8];
        end
      end
      dat_q <= mem[idx];
    end
  end

  assign wbs_o = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

// ==== source/lsu_pkg.sv ====
// LSU package with RV32 decode constants, instruction views and pipeline and bus structs
package lsu_pkg;

  // Data path is one 32-bit word
  localparam int unsigned XLEN  = 32;
  localparam int unsigned EXC_W = 16;

  // Major opcodes, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_OP_IMM = 5'b00100,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_BRANCH = 5'b11000
  } opc_e;

  // Load and store size codes
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;
  localparam logic [2:0] F3_SW  = 3'b010;

  // Bit positions in the exception vector
  localparam int unsigned CAUSE_MISALIGNED_LOAD    = 4;
  localparam int unsigned CAUSE_LOAD_ACCESS_FAULT  = 5;
  localparam int unsigned CAUSE_MISALIGNED_STORE   = 6;
  localparam int unsigned CAUSE_STORE_ACCESS_FAULT = 7;

  // addi x0, x0, 0
  localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

  ////////////////////////////////////////////////////////////
  // Instruction word, I-type and S-type views
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } stype_t;

  typedef union packed {
    itype_t itype;
    stype_t stype;
  } instr_u;

  ////////////////////////////////////////////////////////////
  // Pipeline and bus bundles
  ////////////////////////////////////////////////////////////

  // Operation from execute
  typedef struct packed {
    logic [XLEN-1:0] pc;
    instr_u          instr;
    logic            bubble;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sdata;
    logic [XLEN-1:0] result;
  } ex_op_t;

  // Memory-stage register; mem flags a load or store opcode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    instr_u          instr;
    logic            bubble;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] result;
    logic            mis;
    logic            mem;
  } mem_op_t;

  // Wishbone classic master side, word address
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:2] adr;
    logic [3:0]      sel;
    logic [XLEN-1:0] dat;
  } wbm_req_t;

  typedef struct packed {
    logic            ack;
    logic            err;
    logic [XLEN-1:0] dat;
  } wbs_rsp_t;

  // Register-file write port
  typedef struct packed {
    logic            we;
    logic [4:0]      dst;
    logic [XLEN-1:0] data;
  } rf_wr_t;

endpackage

// ==== source/lsu_top.sv ====
// LSU top level joining the memory stage, the data RAM and the write-back stage
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned              RAM_WORDS = 256,
  parameter logic [lsu_pkg::XLEN-1:0] PC_INIT   = 32'h8000_0000
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  lsu_pkg::ex_op_t           op_i,
  output logic                      ready_o,
  output logic [lsu_pkg::XLEN-1:0]  wb_pc_o,
  output lsu_pkg::instr_u           wb_instr_o,
  output logic                      wb_bubble_o,
  output logic [lsu_pkg::EXC_W-1:0] wb_exception_o,
  output logic [lsu_pkg::XLEN-1:0]  wb_badaddr_o,
  output lsu_pkg::rf_wr_t           rf_o
);
  import lsu_pkg::*;

  // Stage to stage
  mem_op_t  mem_op;
  logic     stall;

  // Bus between master and RAM
  wbm_req_t wbm_req;
  wbs_rsp_t wbs_rsp;

  mem_issue u_mem_issue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .op_i    (op_i),
    .ready_o (ready_o),
    .stall_i (stall),
    .mem_o   (mem_op),
    .wbm_o   (wbm_req)
  );

  data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wbm_i  (wbm_req),
    .wbs_o  (wbs_rsp)
  );

  wb_stage #(.PC_INIT(PC_INIT)) u_wb_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mem_i          (mem_op),
    .wbs_i          (wbs_rsp),
    .stall_o        (stall),
    .wb_pc_o        (wb_pc_o),
    .wb_instr_o     (wb_instr_o),
    .wb_bubble_o    (wb_bubble_o),
    .wb_exception_o (wb_exception_o),
    .wb_badaddr_o   (wb_badaddr_o),
    .rf_o           (rf_o)
  );

endmodule

// ==== source/mem_issue.sv ====
// Memory-access stage: registers the operation, forms address and lanes, runs the bus cycle
`timescale 1ns/1ps

module mem_issue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lsu_pkg::ex_op_t   op_i,
  output logic              ready_o,
  input  logic              stall_i,
  output lsu_pkg::mem_op_t  mem_o,
  output lsu_pkg::wbm_req_t wbm_o
);
  import lsu_pkg::*;

  // Incoming decode
  logic            is_load;
  logic            is_store;
  logic [XLEN-1:0] offset;
  logic [XLEN-1:0] addr_d;
  logic            mis_d;

  // Stage register, control part
  logic            bubble_q;
  logic            mem_q;
  logic            mis_q;
  instr_u          instr_q;

  // Stage register, payload part
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] result_q;
  logic [XLEN-1:0] sdata_q;

  // Bus request terms
  logic            req;
  logic            we_q;
  logic [1:0]      lane;
  logic [3:0]      sel;

  ////////////////////////////////////////////////////////////
  // Effective address and misalignment
  ////////////////////////////////////////////////////////////

  assign is_load  = (op_i.instr.itype.opcode[6:2] == OPC_LOAD);
  assign is_store = (op_i.instr.stype.opcode[6:2] == OPC_STORE);

  // Stores split the immediate around rd
  assign offset = is_store ?
    {{(XLEN-12){op_i.instr.stype.imm_hi[6]}}, op_i.instr.stype.imm_hi, op_i.instr.stype.imm_lo} :
    {{(XLEN-12){op_i.instr.itype.imm[11]}}, op_i.instr.itype.imm};

  assign addr_d = op_i.base + offset;

  always_comb begin
    mis_d = 1'b0;
    if (is_load) begin
      case (op_i.instr.itype.funct3)
        F3_LH, F3_LHU: mis_d = addr_d[0];
        F3_LW:         mis_d = |addr_d[1:0];
        default:       mis_d = 1'b0;
      endcase
    end else if (is_store) begin
      case (op_i.instr.stype.funct3)
        F3_SH:   mis_d = addr_d[0];
        F3_SW:   mis_d = |addr_d[1:0];
        default: mis_d = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage register, holds while write-back stalls
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bubble_q <= 1'b1;
      mem_q    <= 1'b0;
      mis_q    <= 1'b0;
      instr_q  <= INSTR_NOP;
    end else if (!stall_i) begin
      bubble_q <= op_i.bubble;
      mem_q    <= is_load | is_store;
      mis_q    <= mis_d;
      instr_q  <= op_i.instr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      pc_q     <= op_i.pc;
      addr_q   <= addr_d;
      result_q <= op_i.result;
      sdata_q  <= op_i.sdata;
    end
  end

  assign ready_o = ~stall_i;

  assign mem_o = '{pc: pc_q, instr: instr_q, bubble: bubble_q, addr: addr_q,
                   result: result_q, mis: mis_q, mem: mem_q};

  ////////////////////////////////////////////////////////////
  // Wishbone request from the stage register
  ////////////////////////////////////////////////////////////

  // No cycle for bubbles, ALU ops or misaligned accesses
  assign req  = mem_q & ~bubble_q & ~mis_q;
  assign we_q = (instr_q.stype.opcode[6:2] == OPC_STORE);
  assign lane = addr_q[1:0];

  // Size bits of funct3 pick the lane mask
  always_comb begin
    case (instr_q.stype.funct3[1:0])
      2'b00:   sel = 4'b0001 << lane;
      2'b01:   sel = 4'b0011 << lane;
      default: sel = 4'b1111;
    endcase
  end

  assign wbm_o = '{cyc: req, stb: req, we: we_q, adr: addr_q[XLEN-1:2], sel: sel,
                   dat: sdata_q << {lane, 3'b000}};

endmodule

// ==== source/wb_stage.sv ====
// Write-back stage: load extraction, exception vector, memory stall and register-file write
`timescale 1ns/1ps

module wb_stage #(
  parameter logic [lsu_pkg::XLEN-1:0] PC_INIT = 32'h8000_0000
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  lsu_pkg::mem_op_t          mem_i,
  input  lsu_pkg::wbs_rsp_t         wbs_i,
  output logic                      stall_o,
  output logic [lsu_pkg::XLEN-1:0]  wb_pc_o,
  output lsu_pkg::instr_u           wb_instr_o,
  output logic                      wb_bubble_o,
  output logic [lsu_pkg::EXC_W-1:0] wb_exception_o,
  output logic [lsu_pkg::XLEN-1:0]  wb_badaddr_o,
  output lsu_pkg::rf_wr_t           rf_o
);
  import lsu_pkg::*;

  // Decode of the memory-stage word
  logic [4:0]       opc;
  logic [2:0]       funct3;
  logic [4:0]       rd;
  logic             is_load;
  logic             is_store;
  logic             is_branch;

  logic [EXC_W-1:0] exc;
  logic             fault;
  logic [XLEN-1:0]  shifted;
  logic [XLEN-1:0]  ld_data;
  logic             rf_we_d;

  // Register-file write, kept apart for reset
  logic             rf_we_q;
  logic [4:0]       rf_dst_q;
  logic [XLEN-1:0]  rf_data_q;

  assign opc       = mem_i.instr.itype.opcode[6:2];
  assign funct3    = mem_i.instr.itype.funct3;
  assign rd        = mem_i.instr.itype.rd;
  assign is_load   = (opc == OPC_LOAD);
  assign is_store  = (opc == OPC_STORE);
  assign is_branch = (opc == OPC_BRANCH);

  ////////////////////////////////////////////////////////////
  // Stall and exceptions
  ////////////////////////////////////////////////////////////

  // Wait for the slave reply on a live aligned access
  assign stall_o = mem_i.mem & ~mem_i.bubble & ~mem_i.mis & ~(wbs_i.ack | wbs_i.err);

  always_comb begin
    exc = '0;
    if (!mem_i.bubble) begin
      if (is_load) begin
        exc[CAUSE_MISALIGNED_LOAD]   = mem_i.mis;
        exc[CAUSE_LOAD_ACCESS_FAULT] = wbs_i.err;
      end
      if (is_store) begin
        exc[CAUSE_MISALIGNED_STORE]   = mem_i.mis;
        exc[CAUSE_STORE_ACCESS_FAULT] = wbs_i.err;
      end
    end
  end

  assign fault = exc[CAUSE_MISALIGNED_LOAD] | exc[CAUSE_LOAD_ACCESS_FAULT] |
                 exc[CAUSE_MISALIGNED_STORE] | exc[CAUSE_STORE_ACCESS_FAULT];

  ////////////////////////////////////////////////////////////
  // Load data
  ////////////////////////////////////////////////////////////

  // Bring the addressed byte or half down to bit 0
  assign shifted = wbs_i.dat >> {mem_i.addr[1:0], 3'b000};

  always_comb begin
    case (funct3)
      F3_LB:   ld_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      F3_LH:   ld_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      F3_LBU:  ld_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
      F3_LHU:  ld_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
      F3_LW:   ld_data = shifted;
      default: ld_data = shifted;
    endcase
  end

  // x0 never written, stores and branches have no rd
  assign rf_we_d = ~mem_i.bubble & ~fault & (|rd) & ~is_store & ~is_branch;

  ////////////////////////////////////////////////////////////
  // Write-back registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_pc_o        <= PC_INIT;
      wb_instr_o     <= INSTR_NOP;
      wb_bubble_o    <= 1'b1;
      wb_exception_o <= '0;
      rf_we_q        <= 1'b0;
    end else if (!stall_o) begin
      wb_pc_o        <= mem_i.pc;
      wb_instr_o     <= mem_i.instr;
      wb_bubble_o    <= mem_i.bubble;
      wb_exception_o <= exc;
      rf_we_q        <= rf_we_d;
    end
  end

  // Faulting address, else the pc
  always_ff @(posedge clk_i) begin
    if (!stall_o) begin
      wb_badaddr_o <= fault ? mem_i.addr : mem_i.pc;
      rf_dst_q     <= rd;
      rf_data_q    <= is_load ? ld_data : mem_i.result;
    end
  end

  assign rf_o = '{we: rf_we_q, dst: rf_dst_q, data: rf_data_q};

endmodule

// ==== tests/lsu_sva.sv ====
// Bound checks on the LSU Wishbone handshake and the register-file write
`timescale 1ns/1ps

module lsu_sva (
  input logic                      clk_i,
  input logic                      rst_ni,
  input lsu_pkg::wbm_req_t         wbm_i,
  input lsu_pkg::wbs_rsp_t         wbs_i,
  input lsu_pkg::rf_wr_t           rf_i,
  input logic [lsu_pkg::EXC_W-1:0] exc_i
);

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_count;

  initial fail_count = 0;

  // Request frozen until the slave answers
  property req_stable_p;
    @(posedge clk_i) disable iff (!rst_ni)
      (wbm_i.stb && !wbs_i.ack && !wbs_i.err) |=>
        (wbm_i.stb && $stable(wbm_i.adr) && $stable(wbm_i.sel) &&
         $stable(wbm_i.we) && $stable(wbm_i.dat));
  endproperty

  property ack_err_excl_p;
    @(posedge clk_i) disable iff (!rst_ni) !(wbs_i.ack && wbs_i.err);
  endproperty

  // No register write next to a trap
  property we_no_exc_p;
    @(posedge clk_i) disable iff (!rst_ni) rf_i.we |-> (exc_i == '0);
  endproperty

  a_req_stable: assert property (req_stable_p) else begin
    fail_count++;
    $error("Wishbone request changed before ack or err");
  end

  a_ack_err_excl: assert property (ack_err_excl_p) else begin
    fail_count++;
    $error("ack and err high in the same cycle");
  end

  a_we_no_exc: assert property (we_no_exc_p) else begin
    fail_count++;
    $error("Register write together with an exception");
  end

endmodule

bind lsu_top lsu_sva u_sva (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .wbm_i  (wbm_req),
  .wbs_i  (wbs_rsp),
  .rf_i   (rf_o),
  .exc_i  (wb_exception_o)
);

// ==== tests/lsu_tb.sv ====
// Directed testbench for the LSU, checked against a byte-level reference memory
`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int unsigned RAM_WORDS  = 64;
  localparam logic [31:0] PC_INIT    = 32'h0000_1000;
  // Roughly four times the cycles all tests take
  localparam int unsigned MAX_CYCLES = 2000;

  // Expected write-back view of one operation
  typedef struct packed {
    logic [31:0]      pc;
    logic [31:0]      instr;
    logic             bubble;
    logic [EXC_W-1:0] exc;
    logic [31:0]      badaddr;
    logic             we;
    logic [4:0]       dst;
    logic [31:0]      data;
  } expect_t;

  logic             clk_i;
  logic             rst_ni;
  ex_op_t           op_i;
  logic             ready_o;
  logic [XLEN-1:0]  wb_pc_o;
  instr_u           wb_instr_o;
  logic             wb_bubble_o;
  logic [EXC_W-1:0] wb_exception_o;
  logic [XLEN-1:0]  wb_badaddr_o;
  rf_wr_t           rf_o;

  // Reference memory, one entry per byte
  logic [7:0]  model_mem [RAM_WORDS*4];
  expect_t     exp_q [$];
  integer      seed;
  int unsigned cycles;
  logic [31:0] next_pc;

  lsu_top #(.RAM_WORDS(RAM_WORDS), .PC_INIT(PC_INIT)) DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_i           (op_i),
    .ready_o        (ready_o),
    .wb_pc_o        (wb_pc_o),
    .wb_instr_o     (wb_instr_o),
    .wb_bubble_o    (wb_bubble_o),
    .wb_exception_o (wb_exception_o),
    .wb_badaddr_o   (wb_badaddr_o),
    .rf_o           (rf_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: expected write-back did not show up within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "Simulation timed out");
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, act, exp);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // rs1 fixed at x2, rs2 at x7
  function automatic logic [31:0] encode_i(logic [4:0] opc, logic [2:0] f3, logic [4:0] rd,
                                           logic [11:0] imm);
    return {imm, 5'd2, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] encode_s(logic [4:0] opc, logic [2:0] f3, logic [11:0] imm);
    return {imm[11:5], 5'd7, 5'd2, f3, imm[4:0], opc, 2'b11};
  endfunction

  // Base that lands on the target once the offset is added
  function automatic logic [31:0] base_for(logic [31:0] target, logic [11:0] imm);
    return target - {{20{imm[11]}}, imm};
  endfunction

  function automatic ex_op_t idle_op();
    ex_op_t op;
    op        = '0;
    op.instr  = INSTR_NOP;
    op.bubble = 1'b1;
    return op;
  endfunction

  // Reference result, memory updated in program order
  task automatic predict(input ex_op_t op, output expect_t e);
    logic [31:0] w;
    logic [4:0]  opc;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] ld;
    logic        is_ld;
    logic        is_st;
    logic        mis;
    logic        bad;
    int          n;
    w     = op.instr;
    opc   = w[6:2];
    f3    = w[14:12];
    is_ld = (opc == OPC_LOAD);
    is_st = (opc == OPC_STORE);
    if (is_st) a = op.base + {{20{w[31]}}, w[31:25], w[11:7]};
    else       a = op.base + {{20{w[31]}}, w[31:20]};
    n   = 1 << f3[1:0];
    mis = (n == 2 && a[0]) || (n == 4 && a[1:0] != 2'b00);
    bad = !mis && (a[31:2] >= RAM_WORDS);
    e        = '0;
    e.pc     = op.pc;
    e.instr  = w;
    e.bubble = op.bubble;
    e.dst    = w[11:7];
    e.data   = op.result;
    if (!op.bubble && is_ld) begin
      e.exc[CAUSE_MISALIGNED_LOAD]   = mis;
      e.exc[CAUSE_LOAD_ACCESS_FAULT] = bad;
    end
    if (!op.bubble && is_st) begin
      e.exc[CAUSE_MISALIGNED_STORE]   = mis;
      e.exc[CAUSE_STORE_ACCESS_FAULT] = bad;
    end
    e.badaddr = (e.exc != '0) ? a : op.pc;
    e.we = !op.bubble && (e.exc == '0) && (w[11:7] != 5'd0) && !is_st && (opc != OPC_BRANCH);
    if (!op.bubble && e.exc == '0 && is_ld) begin
      ld = '0;
      for (int k = 0; k < n; k++) ld[8*k +: 8] = model_mem[int'(a) + k];
      // funct3 bit 2 marks the unsigned loads
      if (!f3[2] && n == 1) ld[31:8] = {24{ld[7]}};
      if (!f3[2] && n == 2) ld[31:16] = {16{ld[15]}};
      e.data = ld;
    end
    if (!op.bubble && e.exc == '0 && is_st) begin
      for (int k = 0; k < n; k++) model_mem[int'(a) + k] = op.sdata[8*k +: 8];
    end
  endtask

  // Present one operation from a falling edge until it is accepted
  task automatic issue(input logic [31:0] instr, input logic [31:0] base,
                       input logic [31:0] sdata, input logic [31:0] result,
                       input logic bubble);
    ex_op_t  op;
    expect_t e;
    op.pc     = next_pc;
    op.instr  = instr;
    op.bubble = bubble;
    op.base   = base;
    op.sdata  = sdata;
    op.result = result;
    next_pc   = next_pc + 32'd4;
    predict(op, e);
    exp_q.push_back(e);
    op_i = op;
    while (!ready_o) @(negedge clk_i);
    @(negedge clk_i);
    op_i = idle_op();
  endtask

  // Load or store at a target address with a random offset and rd
  task automatic access(input logic st, input logic [2:0] f3, input logic [31:0] addr,
                        input logic [31:0] d);
    logic [31:0] r;
    logic [11:0] imm;
    logic [4:0]  rd;
    r   = $random(seed);
    imm = r[11:0];
    rd  = (r[16:12] == 5'd0) ? 5'd1 : r[16:12];
    if (st) issue(encode_s(OPC_STORE, f3, imm), base_for(addr, imm), d, r, 1'b0);
    else    issue(encode_i(OPC_LOAD, f3, rd, imm), base_for(addr, imm), d, r, 1'b0);
  endtask

  // Wait for the oldest pending pc in write-back, then compare
  task automatic watch();
    expect_t e;
    while (exp_q.size() == 0) @(negedge clk_i);
    e = exp_q.pop_front();
    while (wb_pc_o !== e.pc) @(negedge clk_i);
    check("wb_instr_o", wb_instr_o, e.instr);
    check("wb_bubble_o", wb_bubble_o, e.bubble);
    check("wb_exception_o", wb_exception_o, e.exc);
    check("wb_badaddr_o", wb_badaddr_o, e.badaddr);
    check("rf_o.we", rf_o.we, e.we);
    if (e.we) begin
      check("rf_o.dst", rf_o.dst, e.dst);
      check("rf_o.data", rf_o.data, e.data);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state();
    check("ready_o", ready_o, 1);
    check("wb_bubble_o", wb_bubble_o, 1);
    check("rf_o.we", rf_o.we, 0);
    check("wb_exception_o", wb_exception_o, 0);
    check("wb_pc_o", wb_pc_o, PC_INIT);
  endtask

  task automatic alu_ops();
    issue(encode_i(OPC_OP_IMM, 3'b000, 5'd9, 12'h001), 0, 0, $random(seed), 1'b0);
    watch();
    issue(encode_i(OPC_OP_IMM, 3'b000, 5'd0, 12'h005), 0, 0, $random(seed), 1'b0);
    watch();
    // Branch rd field holds imm bits, still no write
    issue(encode_s(OPC_BRANCH, 3'b001, 12'h01c), 0, 0, $random(seed), 1'b0);
    watch();
    issue(encode_i(OPC_OP, 3'b000, 5'd12, 12'h000), 0, 0, $random(seed), 1'b0);
    watch();
    issue(encode_i(OPC_OP_IMM, 3'b000, 5'd3, 12'h000), 0, 0, $random(seed), 1'b1);
    watch();
  endtask

  task automatic store_then_load();
    logic [31:0] r;
    logic [31:0] addr;
    // Fill words 0 to 15 so later loads read known data
    for (int w = 0; w < 16; w++) begin
      access(1'b1, F3_SW, w * 4, $random(seed));
      watch();
    end
    repeat (12) begin
      r    = $random(seed);
      addr = {28'd0, r[3:2], 2'b00};
      case (r[7:6])
        2'd0:    access(1'b1, F3_SW, addr, $random(seed));
        2'd1:    access(1'b1, F3_SH, addr + {r[8], 1'b0}, $random(seed));
        default: access(1'b1, F3_SB, addr + r[9:8], $random(seed));
      endcase
      watch();
    end
    // Every legal offset of words 0 to 3
    for (int w = 0; w < 4; w++) begin
      access(1'b0, F3_LW, w * 4, 0);
      watch();
      for (int h = 0; h < 4; h += 2) begin
        access(1'b0, F3_LH, w * 4 + h, 0);
        watch();
        access(1'b0, F3_LHU, w * 4 + h, 0);
        watch();
      end
      for (int b = 0; b < 4; b++) begin
        access(1'b0, F3_LB, w * 4 + b, 0);
        watch();
        access(1'b0, F3_LBU, w * 4 + b, 0);
        watch();
      end
    end
  endtask

  task automatic misaligned_ops();
    access(1'b0, F3_LW, 32'd22, 0);
    watch();
    check("misaligned load cause", wb_exception_o[CAUSE_MISALIGNED_LOAD], 1);
    access(1'b1, F3_SH, 32'd25, $random(seed));
    watch();
    check("misaligned store cause", wb_exception_o[CAUSE_MISALIGNED_STORE], 1);
    // Word 6 untouched by the rejected store
    access(1'b0, F3_LW, 32'd24, 0);
    watch();
  endtask

  task automatic access_faults();
    access(1'b0, F3_LW, RAM_WORDS * 4, 0);
    watch();
    check("load fault cause", wb_exception_o[CAUSE_LOAD_ACCESS_FAULT], 1);
    access(1'b1, F3_SW, (RAM_WORDS + 3) * 4, $random(seed));
    watch();
    check("store fault cause", wb_exception_o[CAUSE_STORE_ACCESS_FAULT], 1);
    access(1'b0, F3_LBU, 32'h0001_0002, 0);
    watch();
    // Same low index bits as the faulting store
    access(1'b0, F3_LW, 32'd12, 0);
    watch();
  endtask

  // Random mix, issue and watch run side by side
  task automatic random_op();
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] addr;
    logic [2:0]  f3;
    r    = $random(seed);
    d    = $random(seed);
    addr = {26'd0, r[7:4], (r[12] ? r[9:8] : 2'b00)};
    f3   = r[20:18];
    case (r[2:0])
      3'd0: issue(encode_i(OPC_OP_IMM, 3'b000, r[17:13], 12'h000), 0, 0, d, 1'b0);
      3'd1: issue(encode_i(OPC_OP, 3'b000, r[17:13], 12'h000), 0, 0, d, 1'b0);
      3'd2: issue(encode_s(OPC_BRANCH, 3'b000, r[24:13]), 0, 0, d, 1'b0);
      3'd3, 3'd4: begin
        if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = F3_LW;
        access(1'b0, f3, addr, d);
      end
      3'd5: access(1'b1, (r[19:18] == 2'b11) ? F3_SW : {1'b0, r[19:18]}, addr, d);
      3'd6: access(1'b0, F3_LW, (RAM_WORDS + r[15:13]) * 4, d);
      default: issue(encode_i(OPC_OP_IMM, 3'b000, r[17:13], 12'h000), 0, 0, d, 1'b1);
    endcase
  endtask

  task automatic mixed_stream();
    fork
      begin
        for (int i = 0; i < 40; i++) random_op();
      end
      begin
        repeat (40) watch();
      end
    join
  endtask

  initial begin
    seed    = 32'h181a;
    cycles  = 0;
    next_pc = 32'h0000_0100;
    rst_ni  = 1'b0;
    op_i    = idle_op();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    reset_state();
    alu_ops();
    store_then_load();
    misaligned_ops();
    access_faults();
    mixed_stream();
    repeat (3) @(negedge clk_i);
    if (DUT.u_sva.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", DUT.u_sva.fail_count);
      $display(">>> FAIL");
      $fatal(1, "Assertion failures");
    end
  end

endmodule
